// File: list.f
+incdir+.
csr_pkg.sv
csr_access_unit.sv
csr_trap_regs.sv
perf_counters.sv
csr_top.sv
tb_csr_top.sv

// File: run.sh
#!/bin/sh
# build and run the csr testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_csr_top -f list.f

# a failing run still leaves its log for the search below
./obj_dir/Vtb_csr_top > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation PASSED" sim.log; then
  exit 0
fi
exit 1

// File: tb_csr_ref.svh
`ifndef TB_CSR_REF_SVH
`define TB_CSR_REF_SVH

////////////////////////////////////////////////////////////
// random source
////////////////////////////////////////////////////////////

// taps 32 30 26 25
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
  if (s[0]) begin
    return (s >> 1) ^ 32'hA300_0000;
  end
  return s >> 1;
endfunction

// one step per bit taken and the newest bit lands in bit 0
function automatic csr_data_t rand_bits(input int unsigned n);
  csr_data_t r;
  r = '0;
  for (int unsigned k = 0; k < n; k++) begin
    lfsr_state = lfsr_next(lfsr_state);
    r = {r[30:0], lfsr_state[0]};
  end
  return r;
endfunction

////////////////////////////////////////////////////////////
// register and counter model
////////////////////////////////////////////////////////////

logic             m_mie;
logic             m_mpie;
csr_data_t        m_mepc;
cause_t           m_mcause;
logic [N_CNT-1:0] m_pcer;
logic [1:0]       m_pcmr;
logic [N_CNT-1:0] m_inc_q;
logic             m_idv_q;
csr_data_t        m_cnt [N_CNT];

// 0x780..0x79f
function automatic logic ref_in_pccr(input csr_addr_t a);
  return a[11:5] == 7'h3C;
endfunction

function automatic logic ref_writable(input csr_addr_t a);
  return (a == CSR_MSTATUS) || (a == CSR_MEPC) || (a == CSR_MCAUSE) ||
         (a == CSR_PCER) || (a == CSR_PCMR) || ref_in_pccr(a);
endfunction

function automatic csr_data_t ref_read(input csr_addr_t a);
  csr_data_t r;
  r = '0;
  case (a)
    // mpp fixed to machine mode
    CSR_MSTATUS: r = {19'b0, 2'b11, 3'b0, m_mpie, 3'b0, m_mie, 3'b0};
    CSR_MTVEC:   r = {boot_addr, 8'h00};
    CSR_MEPC:    r = m_mepc;
    CSR_MCAUSE:  r = {m_mcause[5], 26'b0, m_mcause[4:0]};
    CSR_MHARTID: r = {21'b0, cluster_id, 1'b0, core_id};
    CSR_PCER:    r[N_CNT-1:0] = m_pcer;
    CSR_PCMR:    r[1:0] = m_pcmr;
    default: begin
      // all-select and missing indices read zero
      if (ref_in_pccr(a) && (a != CSR_PCCR_ALL)) begin
        for (int i = 0; i < N_CNT; i++) begin
          if (a[4:0] == 5'(i)) begin
            r = m_cnt[i];
          end
        end
      end
    end
  endcase
  return r;
endfunction

function automatic csr_data_t ref_wdata(input csr_op_e op, input csr_data_t d,
                                        input csr_data_t rd);
  case (op)
    CSR_OP_SET:   return d | rd;
    CSR_OP_CLEAR: return rd & ~d;
    default:      return d;
  endcase
endfunction

// counter map 0 cycles 1 instr 2 ld stall 3 jr stall 4 imiss 5 load 6 store
// 7 jump 8 branch 9 taken 10 compressed 11 pc set and then external
function automatic logic [N_CNT-1:0] ref_events(input perf_event_t ev,
                                                input logic [N_EXT_CNT-1:0] ext,
                                                input logic idv_q);
  logic [N_CNT-1:0] e;
  e     = '0;
  e[0]  = 1'b1;
  e[1]  = ev.id_valid & ev.is_decoding;
  e[2]  = ev.ld_stall & idv_q;
  e[3]  = ev.jr_stall & idv_q;
  e[4]  = ev.imiss & !ev.pc_set;
  e[5]  = ev.mem_load;
  e[6]  = ev.mem_store;
  e[7]  = ev.jump & idv_q;
  e[8]  = ev.branch & idv_q;
  e[9]  = ev.branch & ev.branch_taken & idv_q;
  e[10] = ev.id_valid & ev.is_decoding & ev.is_compressed;
  e[11] = ev.pc_set;
  e[N_CNT-1:N_CORE_EVENTS] = ext;
  return e;
endfunction

task automatic model_reset();
  m_mie    = 1'b0;
  m_mpie   = 1'b0;
  m_mepc   = '0;
  m_mcause = '0;
  m_pcer   = '0;
  m_pcmr   = 2'b11;
  m_inc_q  = '0;
  m_idv_q  = 1'b0;
  for (int i = 0; i < N_CNT; i++) begin
    m_cnt[i] = '0;
  end
endtask

// one rising edge with every new value taken from the state before it
task automatic model_step();
  csr_addr_t        a;
  csr_data_t        wd;
  logic             we;
  logic             old_mie;
  logic             old_mpie;
  logic [N_CNT-1:0] inc_now;
  a        = csr_req.addr;
  wd       = ref_wdata(csr_req.op, csr_req.wdata, ref_read(a));
  we       = csr_req.access && (csr_req.op != CSR_OP_NONE) && ref_writable(a);
  old_mie  = m_mie;
  old_mpie = m_mpie;
  inc_now  = ref_events(events, ext_events, m_idv_q) & m_pcer & {N_CNT{m_pcmr[0]}};

  for (int i = 0; i < N_CNT; i++) begin
    if (m_inc_q[i] && !(m_pcmr[1] && (m_cnt[i] == 32'hFFFF_FFFF))) begin
      m_cnt[i] = m_cnt[i] + 32'd1;
    end
    if (we && ref_in_pccr(a) && ((a == CSR_PCCR_ALL) || (a[4:0] == 5'(i)))) begin
      m_cnt[i] = wd;
    end
  end
  m_inc_q = inc_now;
  m_idv_q = events.id_valid;

  if (we && (a == CSR_PCER)) begin
    m_pcer = wd[N_CNT-1:0];
  end
  if (we && (a == CSR_PCMR)) begin
    m_pcmr = wd[1:0];
  end
  if (we && (a == CSR_MSTATUS)) begin
    m_mie  = wd[3];
    m_mpie = wd[7];
  end
  if (we && (a == CSR_MEPC)) begin
    m_mepc = wd;
  end
  if (we && (a == CSR_MCAUSE)) begin
    m_mcause = {wd[31], wd[4:0]};
  end

  // trap entry beats mret and both beat the csr port
  if (trap.save_cause) begin
    m_mpie   = old_mie;
    m_mie    = 1'b0;
    m_mepc   = trap.save_if ? pc_if : pc_id;
    m_mcause = trap.cause;
  end else if (trap.restore_mret) begin
    m_mie  = old_mpie;
    m_mpie = 1'b1;
  end
endtask

////////////////////////////////////////////////////////////
// compare tasks
////////////////////////////////////////////////////////////

task automatic check_data(input string name, input csr_data_t exp, input csr_data_t act);
  if (exp !== act) begin
    $display("** Error: %s expected %h actual %h", name, exp, act);
    $display("Simulation FAILED");
    $fatal(1, "stopped at the first mismatch");
  end
endtask

task automatic check_tvec(input string name, input tvec_t exp, input tvec_t act);
  if (exp !== act) begin
    $display("** Error: %s expected %h actual %h", name, exp, act);
    $display("Simulation FAILED");
    $fatal(1, "stopped at the first mismatch");
  end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
  if (exp !== act) begin
    $display("** Error: %s expected %b actual %b", name, exp, act);
    $display("Simulation FAILED");
    $fatal(1, "stopped at the first mismatch");
  end
endtask

`endif

// File: tb_csr_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_csr_top;
  import csr_pkg::*;

  localparam int unsigned N_EXT_CNT  = 2;
  localparam int unsigned N_CNT      = N_CORE_EVENTS + N_EXT_CNT;
  localparam logic [31:0] LFSR_SEED  = 32'd32015;
  localparam int unsigned WAIT_LIMIT = 16;

  logic                 clk;
  logic                 rst_n;
  csr_req_t             csr_req;
  trap_ctrl_t           trap;
  csr_data_t            pc_if;
  csr_data_t            pc_id;
  tvec_t                boot_addr;
  logic [3:0]           core_id;
  logic [5:0]           cluster_id;
  perf_event_t          events;
  logic [N_EXT_CNT-1:0] ext_events;
  csr_data_t            dut_rdata;
  csr_data_t            dut_mepc;
  tvec_t                dut_mtvec;
  logic                 dut_irq_en;

  string                test_name;
  logic [31:0]          lfsr_state;

  `include "tb_csr_ref.svh"

  csr_top #(
    .N_EXT_CNT (N_EXT_CNT)
  ) UUT (
    .clk            (clk),
    .rst_n          (rst_n),
    .csr_req_i      (csr_req),
    .csr_rdata_o    (dut_rdata),
    .trap_i         (trap),
    .pc_if_i        (pc_if),
    .pc_id_i        (pc_id),
    .boot_addr_i    (boot_addr),
    .core_id_i      (core_id),
    .cluster_id_i   (cluster_id),
    .events_i       (events),
    .ext_events_i   (ext_events),
    .mepc_o         (dut_mepc),
    .mtvec_o        (dut_mtvec),
    .m_irq_enable_o (dut_irq_en)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // model follows the dut edge by edge
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      model_reset();
    end else begin
      model_step();
    end
  end

  // sampled mid-cycle where inputs and read data have settled
  always @(negedge clk) begin
    if (rst_n) begin
      check_data(test_name, ref_read(csr_req.addr), dut_rdata);
      check_data({test_name, " mepc_o"}, m_mepc, dut_mepc);
      check_tvec({test_name, " mtvec_o"}, boot_addr, dut_mtvec);
      check_bit({test_name, " m_irq_enable_o"}, m_mie, dut_irq_en);
    end
  end

  ////////////////////////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////////////////////////

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic drive_idle();
    csr_req.access = 1'b0;
    csr_req.addr   = '0;
    csr_req.wdata  = '0;
    csr_req.op     = CSR_OP_NONE;
    trap           = '0;
  endtask

  task automatic drive_csr(input csr_addr_t a, input csr_data_t d, input csr_op_e op);
    next_cycle();
    drive_idle();
    csr_req.access = 1'b1;
    csr_req.addr   = a;
    csr_req.wdata  = d;
    csr_req.op     = op;
  endtask

  task automatic drive_events();
    csr_data_t r;
    r          = rand_bits(12);
    events     = perf_event_t'(r[11:0]);
    r          = rand_bits(N_EXT_CNT);
    ext_events = r[N_EXT_CNT-1:0];
  endtask

  function automatic int unsigned rand_index();
    csr_data_t r;
    r = rand_bits(5);
    return r % N_CNT;
  endfunction

  function automatic csr_addr_t pick_addr(input logic [9:0] sel);
    case (sel[1:0])
      2'd0:    return CSR_MEPC;
      2'd1:    return CSR_MSTATUS;
      2'd2:    return CSR_MCAUSE;
      // nothing lives at 0xc00..0xcff
      default: return {4'hC, sel[9:2]};
    endcase
  endfunction

  // counter reads are polled until the value shows up
  task automatic wait_counter(input int unsigned idx, input csr_data_t value,
                              input int unsigned limit);
    int unsigned n;
    logic        hit;
    drive_csr(CSR_PCCR_BASE + 12'(idx), '0, CSR_OP_NONE);
    n   = 0;
    hit = 1'b0;
    while (!hit && (n < limit)) begin
      @(negedge clk);
      hit = (dut_rdata === value);
      n++;
    end
    if (!hit) begin
      $display("timeout: counter %0d never read %h within %0d cycles", idx, value, limit);
      $display("Simulation FAILED");
      $fatal(1, "counter wait timed out");
    end
  endtask

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    csr_data_t r;
    csr_data_t d;
    csr_addr_t a;
    csr_op_e   op;

    lfsr_state = LFSR_SEED;
    test_name  = "reset";
    rst_n      = 1'b0;
    drive_idle();
    pc_if      = '0;
    pc_id      = '0;
    events     = '0;
    ext_events = '0;
    r          = rand_bits(24);
    boot_addr  = r[23:0];
    r          = rand_bits(10);
    core_id    = r[3:0];
    cluster_id = r[9:4];
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;

    test_name = "reset_values";
    drive_csr(CSR_MSTATUS, '0, CSR_OP_NONE);
    drive_csr(CSR_MTVEC, '0, CSR_OP_NONE);
    drive_csr(CSR_MHARTID, '0, CSR_OP_NONE);
    drive_csr(CSR_PCMR, '0, CSR_OP_NONE);
    drive_csr(CSR_PCER, '0, CSR_OP_NONE);
    drive_csr(CSR_MEPC, '0, CSR_OP_NONE);
    drive_csr(CSR_MCAUSE, '0, CSR_OP_NONE);

    // random op on a random register and a read back
    test_name = "csr_ops";
    for (int i = 0; i < 48; i++) begin
      r  = rand_bits(12);
      op = csr_op_e'(r[1:0]);
      a  = pick_addr(r[11:2]);
      d  = rand_bits(32);
      drive_csr(a, d, op);
      drive_csr(a, '0, CSR_OP_NONE);
    end

    test_name = "trap_entry";
    for (int i = 0; i < 16; i++) begin
      r = rand_bits(8);
      drive_csr(CSR_MSTATUS, {24'h0, r[1], 3'b0, r[0], 3'b0}, CSR_OP_WRITE);
      d = rand_bits(32);
      drive_csr(pick_addr({8'h00, r[4:3]}), d, r[2] ? CSR_OP_WRITE : CSR_OP_NONE);
      pc_if             = rand_bits(32);
      pc_id             = rand_bits(32);
      d                 = rand_bits(6);
      trap.save_cause   = 1'b1;
      trap.save_if      = r[6];
      trap.save_id      = !r[6];
      trap.cause        = d[5:0];
      drive_csr(CSR_MEPC, '0, CSR_OP_NONE);
      drive_csr(CSR_MCAUSE, '0, CSR_OP_NONE);
      drive_csr(CSR_MSTATUS, rand_bits(32), r[5] ? CSR_OP_SET : CSR_OP_NONE);
      trap.restore_mret = 1'b1;
      drive_csr(CSR_MSTATUS, '0, CSR_OP_NONE);
    end

    // round 0 wraps and round 1 saturates
    test_name = "event_count";
    for (int round = 0; round < 2; round++) begin
      drive_csr(CSR_PCMR, (round == 0) ? 32'h1 : 32'h3, CSR_OP_WRITE);
      drive_csr(CSR_PCCR_ALL, '0, CSR_OP_WRITE);
      drive_csr(CSR_PCER, rand_bits(N_CNT), CSR_OP_WRITE);
      drive_csr(CSR_PCER, '0, CSR_OP_NONE);
      for (int i = 0; i < 80; i++) begin
        drive_csr(CSR_PCCR_BASE + 12'(rand_index()), '0, CSR_OP_NONE);
        drive_events();
      end
      for (int idx = 0; idx < N_CNT; idx++) begin
        drive_csr(CSR_PCCR_BASE + 12'(idx), '0, CSR_OP_NONE);
        events     = '0;
        ext_events = '0;
      end
    end

    test_name = "saturate";
    drive_csr(CSR_PCER, (32'h1 << N_CNT) - 32'h1, CSR_OP_WRITE);
    drive_csr(CSR_PCMR, 32'h3, CSR_OP_WRITE);
    drive_csr(CSR_PCCR_ALL, 32'hFFFF_FFFE, CSR_OP_WRITE);
    wait_counter(0, 32'hFFFF_FFFF, WAIT_LIMIT);
    for (int i = 0; i < 4; i++) begin
      drive_csr(CSR_PCCR_BASE, '0, CSR_OP_NONE);
    end
    test_name = "wrap";
    drive_csr(CSR_PCMR, 32'h1, CSR_OP_WRITE);
    wait_counter(0, 32'h0, WAIT_LIMIT);

    test_name = "global_disable";
    drive_csr(CSR_PCMR, 32'h0, CSR_OP_WRITE);
    drive_csr(CSR_PCCR_ALL, rand_bits(32), CSR_OP_WRITE);
    for (int i = 0; i < 30; i++) begin
      drive_csr(CSR_PCCR_BASE + 12'(rand_index()), '0, CSR_OP_NONE);
      drive_events();
    end
    test_name = "missing_index";
    drive_csr(CSR_PCCR_BASE + 12'(N_CNT), rand_bits(32), CSR_OP_WRITE);
    for (int idx = N_CNT; idx < 32; idx++) begin
      drive_csr(CSR_PCCR_BASE + 12'(idx), '0, CSR_OP_NONE);
    end
    for (int idx = 0; idx < N_CNT; idx++) begin
      drive_csr(CSR_PCCR_BASE + 12'(idx), '0, CSR_OP_NONE);
    end

    next_cycle();
    drive_idle();
    next_cycle();
    $display("Simulation PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: csr_top.sv
`timescale 1ns/1ps
`default_nettype none

module csr_top #(
  parameter int unsigned N_EXT_CNT = 2
) (
  input  wire logic                 clk,
  input  wire logic                 rst_n,
  input  wire csr_pkg::csr_req_t    csr_req_i,
  output csr_pkg::csr_data_t        csr_rdata_o,
  input  wire csr_pkg::trap_ctrl_t  trap_i,
  input  wire csr_pkg::csr_data_t   pc_if_i,
  input  wire csr_pkg::csr_data_t   pc_id_i,
  input  wire csr_pkg::tvec_t       boot_addr_i,
  input  wire logic [3:0]           core_id_i,
  input  wire logic [5:0]           cluster_id_i,
  input  wire csr_pkg::perf_event_t events_i,
  input  wire logic [N_EXT_CNT-1:0] ext_events_i,
  output csr_pkg::csr_data_t        mepc_o,
  output csr_pkg::tvec_t            mtvec_o,
  output logic                      m_irq_enable_o
);
  import csr_pkg::*;

  csr_target_t target;
  csr_data_t   wdata;
  logic        csr_we;
  csr_data_t   mach_rdata;
  csr_data_t   perf_rdata;

  ////////////////////////////////////////////////////////////
  // decode and operation resolve
  ////////////////////////////////////////////////////////////

  csr_access_unit u_access (
    .csr_req_i    (csr_req_i),
    .mach_rdata_i (mach_rdata),
    .perf_rdata_i (perf_rdata),
    .target_o     (target),
    .wdata_o      (wdata),
    .we_o         (csr_we),
    .csr_rdata_o  (csr_rdata_o)
  );

  // machine registers and trap sequencing
  csr_trap_regs u_trap (
    .clk            (clk),
    .rst_n          (rst_n),
    .target_i       (target),
    .addr_i         (csr_req_i.addr),
    .wdata_i        (wdata),
    .we_i           (csr_we),
    .trap_i         (trap_i),
    .pc_if_i        (pc_if_i),
    .pc_id_i        (pc_id_i),
    .boot_addr_i    (boot_addr_i),
    .core_id_i      (core_id_i),
    .cluster_id_i   (cluster_id_i),
    .mach_rdata_o   (mach_rdata),
    .mepc_o         (mepc_o),
    .mtvec_o        (mtvec_o),
    .m_irq_enable_o (m_irq_enable_o)
  );

  // event counters
  perf_counters #(
    .N_EXT_CNT (N_EXT_CNT)
  ) u_perf (
    .clk          (clk),
    .rst_n        (rst_n),
    .target_i     (target),
    .wdata_i      (wdata),
    .we_i         (csr_we),
    .events_i     (events_i),
    .ext_events_i (ext_events_i),
    .perf_rdata_o (perf_rdata)
  );

endmodule

`default_nettype wire

// File: perf_counters.sv
`timescale 1ns/1ps
`default_nettype none

module perf_counters #(
  parameter int unsigned N_EXT_CNT = 2
) (
  input  wire logic                 clk,
  input  wire logic                 rst_n,
  input  wire csr_pkg::csr_target_t target_i,
  input  wire csr_pkg::csr_data_t   wdata_i,
  input  wire logic                 we_i,
  input  wire csr_pkg::perf_event_t events_i,
  input  wire logic [N_EXT_CNT-1:0] ext_events_i,
  output csr_pkg::csr_data_t        perf_rdata_o
);
  import csr_pkg::*;

  localparam int unsigned N_CNT = N_CORE_EVENTS + N_EXT_CNT;

  logic                    id_valid_q;
  logic [N_CNT-1:0]        cnt_in;
  logic [N_CNT-1:0]        cnt_inc;
  logic [N_CNT-1:0]        cnt_inc_q;
  logic [N_CNT-1:0]        pcer_q;
  logic [N_CNT-1:0]        pcer_n;
  logic [1:0]              pcmr_q;
  logic [1:0]              pcmr_n;
  csr_data_t [N_CNT-1:0]   cnt_q;
  csr_data_t [N_CNT-1:0]   cnt_n;
  logic                    pccr_we;

  ////////////////////////////////////////////////////////////
  // event sources
  ////////////////////////////////////////////////////////////

  assign cnt_in[0]  = 1'b1;
  // retired instructions
  assign cnt_in[1]  = events_i.id_valid & events_i.is_decoding;
  assign cnt_in[2]  = events_i.ld_stall & id_valid_q;
  assign cnt_in[3]  = events_i.jr_stall & id_valid_q;
  // fetch wait, redirects excluded
  assign cnt_in[4]  = events_i.imiss & ~events_i.pc_set;
  assign cnt_in[5]  = events_i.mem_load;
  assign cnt_in[6]  = events_i.mem_store;
  assign cnt_in[7]  = events_i.jump & id_valid_q;
  assign cnt_in[8]  = events_i.branch & id_valid_q;
  assign cnt_in[9]  = events_i.branch & events_i.branch_taken & id_valid_q;
  assign cnt_in[10] = events_i.id_valid & events_i.is_decoding & events_i.is_compressed;
  // pc redirects
  assign cnt_in[11] = events_i.pc_set;

  assign cnt_in[N_CORE_EVENTS +: N_EXT_CNT] = ext_events_i;

  // global enable gates everything before the pipeline stage
  assign cnt_inc = cnt_in & pcer_q & {N_CNT{pcmr_q[PCMR_EN_BIT]}};

  assign pccr_we = we_i & target_i.sel_pccr;

  ////////////////////////////////////////////////////////////
  // counter update
  ////////////////////////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < N_CNT; i++) begin
      cnt_n[i] = cnt_q[i];
      if (cnt_inc_q[i] && ((cnt_q[i] != 32'hFFFF_FFFF) || !pcmr_q[PCMR_SAT_BIT])) begin
        cnt_n[i] = cnt_q[i] + 32'd1;
      end
      // a csr write replaces the increment
      if (pccr_we && (target_i.pccr_all || (target_i.pccr_idx == cnt_idx_t'(i)))) begin
        cnt_n[i] = wdata_i;
      end
    end
  end

  assign pcer_n = (we_i && target_i.sel_pcer) ? wdata_i[N_CNT-1:0] : pcer_q;
  assign pcmr_n = (we_i && target_i.sel_pcmr) ? wdata_i[1:0] : pcmr_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      id_valid_q <= 1'b0;
      pcer_q     <= '0;
      pcmr_q     <= PCMR_RESET;
      cnt_inc_q  <= '0;
      cnt_q      <= '0;
    end else begin
      id_valid_q <= events_i.id_valid;
      pcer_q     <= pcer_n;
      pcmr_q     <= pcmr_n;
      cnt_inc_q  <= cnt_inc;
      cnt_q      <= cnt_n;
    end
  end

  ////////////////////////////////////////////////////////////
  // read data
  ////////////////////////////////////////////////////////////

  always_comb begin
    perf_rdata_o = '0;
    if (target_i.sel_pcer) begin
      perf_rdata_o[N_CNT-1:0] = pcer_q;
    end else if (target_i.sel_pcmr) begin
      perf_rdata_o[1:0] = pcmr_q;
    end else if (target_i.sel_pccr && !target_i.pccr_all) begin
      // indices past the last counter stay zero
      for (int i = 0; i < N_CNT; i++) begin
        if (target_i.pccr_idx == cnt_idx_t'(i)) begin
          perf_rdata_o = cnt_q[i];
        end
      end
    end
  end

  // counters must fit the 0x780..0x79f window and the pcer word
  a_cnt_fits: assert property (@(posedge clk) disable iff (!rst_n) N_CNT <= 32)
    else $error("too many performance counters");

endmodule

`default_nettype wire

// File: csr_trap_regs.sv
`timescale 1ns/1ps
`default_nettype none

module csr_trap_regs (
  input  wire logic                 clk,
  input  wire logic                 rst_n,
  input  wire csr_pkg::csr_target_t target_i,
  input  wire csr_pkg::csr_addr_t   addr_i,
  input  wire csr_pkg::csr_data_t   wdata_i,
  input  wire logic                 we_i,
  input  wire csr_pkg::trap_ctrl_t  trap_i,
  input  wire csr_pkg::csr_data_t   pc_if_i,
  input  wire csr_pkg::csr_data_t   pc_id_i,
  input  wire csr_pkg::tvec_t       boot_addr_i,
  input  wire logic [3:0]           core_id_i,
  input  wire logic [5:0]           cluster_id_i,
  output csr_pkg::csr_data_t        mach_rdata_o,
  output csr_pkg::csr_data_t        mepc_o,
  output csr_pkg::tvec_t            mtvec_o,
  output logic                      m_irq_enable_o
);
  import csr_pkg::*;

  mstatus_t  mstatus_q;
  mstatus_t  mstatus_n;
  csr_data_t mepc_q;
  csr_data_t mepc_n;
  cause_t    mcause_q;
  cause_t    mcause_n;
  csr_data_t exc_pc;
  csr_data_t mstatus_rd;
  logic      mach_we;

  // we_i also fires for perf targets
  assign mach_we = we_i & target_i.sel_mach;

  ////////////////////////////////////////////////////////////
  // read data
  ////////////////////////////////////////////////////////////

  always_comb begin
    mstatus_rd                                = '0;
    mstatus_rd[MSTATUS_MIE_BIT]               = mstatus_q.mie;
    mstatus_rd[MSTATUS_MPIE_BIT]              = mstatus_q.mpie;
    mstatus_rd[MSTATUS_MPP_LSB +: 2]          = MSTATUS_MPP_M;
  end

  always_comb begin
    unique case (addr_i)
      CSR_MSTATUS: mach_rdata_o = mstatus_rd;
      CSR_MTVEC:   mach_rdata_o = {boot_addr_i, 8'h00};
      CSR_MEPC:    mach_rdata_o = mepc_q;
      CSR_MCAUSE:  mach_rdata_o = {mcause_q[5], 26'b0, mcause_q[4:0]};
      // hart id packs cluster and core
      CSR_MHARTID: mach_rdata_o = {21'b0, cluster_id_i, 1'b0, core_id_i};
      default:     mach_rdata_o = '0;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // next state
  ////////////////////////////////////////////////////////////

  always_comb begin
    mstatus_n = mstatus_q;
    mepc_n    = mepc_q;
    mcause_n  = mcause_q;
    exc_pc    = trap_i.save_if ? pc_if_i : pc_id_i;

    // software access
    if (mach_we) begin
      unique case (addr_i)
        CSR_MSTATUS: begin
          mstatus_n.mie  = wdata_i[MSTATUS_MIE_BIT];
          mstatus_n.mpie = wdata_i[MSTATUS_MPIE_BIT];
        end
        CSR_MEPC:   mepc_n   = wdata_i;
        CSR_MCAUSE: mcause_n = {wdata_i[31], wdata_i[4:0]};
        default: ;
      endcase
    end

    // controller wins over the csr port
    if (trap_i.save_cause) begin
      mstatus_n.mpie = mstatus_q.mie;
      mstatus_n.mie  = 1'b0;
      mepc_n         = exc_pc;
      mcause_n       = trap_i.cause;
    end else if (trap_i.restore_mret) begin
      mstatus_n.mie  = mstatus_q.mpie;
      mstatus_n.mpie = 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mstatus_q <= '0;
      mepc_q    <= '0;
      mcause_q  <= '0;
    end else begin
      mstatus_q <= mstatus_n;
      mepc_q    <= mepc_n;
      mcause_q  <= mcause_n;
    end
  end

  assign mepc_o         = mepc_q;
  assign mtvec_o        = boot_addr_i;
  assign m_irq_enable_o = mstatus_q.mie;

  ////////////////////////////////////////////////////////////
  // controller protocol checks
  ////////////////////////////////////////////////////////////

  a_save_vs_mret: assert property (@(posedge clk) disable iff (!rst_n)
    !(trap_i.save_cause && trap_i.restore_mret))
    else $error("trap entry and mret requested together");

  a_save_pc_src: assert property (@(posedge clk) disable iff (!rst_n)
    trap_i.save_cause |-> !(trap_i.save_if && trap_i.save_id))
    else $error("trap entry with both IF and ID pc selected");

endmodule

`default_nettype wire

// File: csr_access_unit.sv
`timescale 1ns/1ps
`default_nettype none

module csr_access_unit (
  input  wire csr_pkg::csr_req_t    csr_req_i,
  input  wire csr_pkg::csr_data_t   mach_rdata_i,
  input  wire csr_pkg::csr_data_t   perf_rdata_i,
  output csr_pkg::csr_target_t      target_o,
  output csr_pkg::csr_data_t        wdata_o,
  output logic                      we_o,
  output csr_pkg::csr_data_t        csr_rdata_o
);
  import csr_pkg::*;

  csr_target_t target;
  logic        mach_rw;
  logic        writable;

  ////////////////////////////////////////////////////////////
  // address decode
  ////////////////////////////////////////////////////////////

  always_comb begin
    target          = '0;
    mach_rw         = 1'b0;
    target.pccr_idx = csr_req_i.addr[4:0];

    unique case (csr_req_i.addr)
      CSR_MSTATUS, CSR_MEPC, CSR_MCAUSE: begin
        target.sel_mach = 1'b1;
        mach_rw         = 1'b1;
      end
      // read-only machine registers
      CSR_MTVEC, CSR_MHARTID: begin
        target.sel_mach = 1'b1;
      end
      CSR_PCER: begin
        target.sel_pcer = 1'b1;
      end
      CSR_PCMR: begin
        target.sel_pcmr = 1'b1;
      end
      default: begin
        // counter window where 0x79f selects all of them
        if (csr_req_i.addr[11:5] == CSR_PCCR_BASE[11:5]) begin
          target.sel_pccr = 1'b1;
          target.pccr_all = (csr_req_i.addr == CSR_PCCR_ALL);
        end
      end
    endcase
  end

  assign writable = mach_rw | target.sel_pcer | target.sel_pcmr | target.sel_pccr;
  assign target_o = target;

  // read source
  always_comb begin
    csr_rdata_o = '0;
    if (target.sel_mach) begin
      csr_rdata_o = mach_rdata_i;
    end else if (target.sel_pcer || target.sel_pcmr || target.sel_pccr) begin
      csr_rdata_o = perf_rdata_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // operation resolve
  ////////////////////////////////////////////////////////////

  always_comb begin
    unique case (csr_req_i.op)
      CSR_OP_WRITE: wdata_o = csr_req_i.wdata;
      CSR_OP_SET:   wdata_o = csr_req_i.wdata | csr_rdata_o;
      CSR_OP_CLEAR: wdata_o = csr_rdata_o & ~csr_req_i.wdata;
      default:      wdata_o = csr_req_i.wdata;
    endcase
  end

  // unmapped or read-only addresses never write
  assign we_o = csr_req_i.access && (csr_req_i.op != CSR_OP_NONE) && writable;

endmodule

`default_nettype wire

// File: csr_pkg.sv
`default_nettype none

package csr_pkg;

  ////////////////////////////////////////////////////////////
  // widths with a meaning
  ////////////////////////////////////////////////////////////

  typedef logic [11:0] csr_addr_t;
  typedef logic [31:0] csr_data_t;
  // trap vector base, low 8 bits read as zero
  typedef logic [23:0] tvec_t;
  // msb flags an interrupt
  typedef logic [5:0]  cause_t;
  // counter index inside the 0x780 window
  typedef logic [4:0]  cnt_idx_t;

  typedef enum logic [1:0] {
    CSR_OP_NONE  = 2'b00,
    CSR_OP_WRITE = 2'b01,
    CSR_OP_SET   = 2'b10,
    CSR_OP_CLEAR = 2'b11
  } csr_op_e;

  ////////////////////////////////////////////////////////////
  // address map
  ////////////////////////////////////////////////////////////

  localparam csr_addr_t CSR_MSTATUS   = 12'h300;
  localparam csr_addr_t CSR_MTVEC     = 12'h305;
  localparam csr_addr_t CSR_MEPC      = 12'h341;
  localparam csr_addr_t CSR_MCAUSE    = 12'h342;
  localparam csr_addr_t CSR_MHARTID   = 12'hF14;
  localparam csr_addr_t CSR_PCER      = 12'h7A0;
  localparam csr_addr_t CSR_PCMR      = 12'h7A1;
  localparam csr_addr_t CSR_PCCR_ALL  = 12'h79F;
  // 0x780..0x79f, decoded on bits 11:5
  localparam csr_addr_t CSR_PCCR_BASE = 12'h780;

  // mstatus layout, mpp always reads as machine mode
  localparam int unsigned MSTATUS_MIE_BIT  = 3;
  localparam int unsigned MSTATUS_MPIE_BIT = 7;
  localparam int unsigned MSTATUS_MPP_LSB  = 11;
  localparam logic [1:0]  MSTATUS_MPP_M    = 2'b11;

  // perf counter setup
  localparam int unsigned N_CORE_EVENTS = 12;
  localparam int unsigned PCMR_EN_BIT   = 0;
  localparam int unsigned PCMR_SAT_BIT  = 1;
  localparam logic [1:0]  PCMR_RESET    = 2'b11;

  typedef struct packed {
    logic      access;
    csr_addr_t addr;
    csr_data_t wdata;
    csr_op_e   op;
  } csr_req_t;

  typedef struct packed {
    logic     sel_mach;
    logic     sel_pcer;
    logic     sel_pcmr;
    logic     sel_pccr;
    logic     pccr_all;
    cnt_idx_t pccr_idx;
  } csr_target_t;

  typedef struct packed {
    logic   save_cause;
    logic   save_if;
    logic   save_id;
    logic   restore_mret;
    cause_t cause;
  } trap_ctrl_t;

  typedef struct packed {
    logic mie;
    logic mpie;
  } mstatus_t;

  typedef struct packed {
    logic id_valid;
    logic is_decoding;
    logic is_compressed;
    logic imiss;
    logic pc_set;
    logic jump;
    logic branch;
    logic branch_taken;
    logic ld_stall;
    logic jr_stall;
    logic mem_load;
    logic mem_store;
  } perf_event_t;

endpackage

`default_nettype wire
